/* design/rvPkg.sv */
// Word-only RV32I subset; no system, fence, CSR, byte or halfword encodings
`default_nettype none

package rvPkg;

    // Major opcodes, one per supported group
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opOpImm  = 7'b0010011
    } rvOpcode_e;

    typedef enum logic [2:0] {
        stFetch, stDecode, stExecute, stMemory, stWriteback
    } ctrlState_e;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOp_e;

    typedef struct packed {
        logic eq;   // a == b
        logic lt;   // Signed a < b
        logic ltu;  // Unsigned a < b
    } cmpFlags_t;

    // Operand A sources
    typedef enum logic [1:0] {aPc, aRs1, aOldPc} aSel_e;

    // Operand B sources
    typedef enum logic [1:0] {bRs2, bImm, bFour} bSel_e;

    // Writeback sources
    typedef enum logic [1:0] {wbAlu, wbMdr, wbImm, wbLink} wbSel_e;

    typedef struct packed {
        logic   pcWrite;
        logic   irWrite;      // Also loads oldPc
        logic   adrFromAlu;   // Memory address from ALU out, else PC
        logic   memWe;
        logic   regWrite;
        logic   aluOutWrite;
        logic   mdrWrite;
        aSel_e  aSel;
        bSel_e  bSel;
        wbSel_e wbSel;
        aluOp_e aluOp;
    } ctrlBus_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } memReq_t;

endpackage

`default_nettype wire

/* design/rvAlu.sv */
// Combinational; shifts use b[4:0] and flags always compare a with b
`default_nettype none

module rvAlu import rvPkg::*; (
    input  wire [31:0]  a,
    input  wire [31:0]  b,
    input  wire aluOp_e op,
    output logic [31:0] result,
    output cmpFlags_t   flags
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    assign flags.eq  = (a == b);
    assign flags.lt  = ($signed(a) < $signed(b));
    assign flags.ltu = (a < b);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluSll:  result = a << shamt;
            aluSlt:  result = {31'b0, flags.lt};
            aluSltu: result = {31'b0, flags.ltu};
            aluXor:  result = a ^ b;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $signed(a) >>> shamt;   // Sign fill
            aluOr:   result = a | b;
            aluAnd:  result = a & b;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/rvRegFile.sv */
// x1 to x31 clear on reset; x0 reads zero and ignores writes
`default_nettype none

module rvRegFile (
    input  wire         clk,
    input  wire         arstN,
    input  wire [4:0]   rs1Addr,
    input  wire [4:0]   rs2Addr,
    input  wire [4:0]   rdAddr,
    input  wire [31:0]  rdData,
    input  wire         rdWe,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [1:31];   // No storage for x0

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWe && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    // Asynchronous reads
    assign rs1Data = (rs1Addr == 5'd0) ? 32'd0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? 32'd0 : regs[rs2Addr];

endmodule

`default_nettype wire

/* design/rvControl.sv */
// Fixed five-cycle sequencer; unknown opcodes step through the states with no writes
`default_nettype none

module rvControl import rvPkg::*; (
    input  wire            clk,
    input  wire            arstN,
    input  wire rvOpcode_e opcode,
    input  wire [2:0]      func3,
    input  wire            instr30,
    input  wire cmpFlags_t flags,
    output ctrlBus_t       ctrl
);

    ctrlState_e state;
    aluOp_e     funcOp;   // Operation from func3 and bit 30
    logic       taken;    // Branch rule result

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stFetch;
        end else begin
            case (state)
                stFetch:   state <= stDecode;
                stDecode:  state <= stExecute;
                stExecute: state <= stMemory;
                stMemory:  state <= stWriteback;
                default:   state <= stFetch;   // Writeback wraps to fetch
            endcase
        end
    end

    always_comb begin
        case (func3)
            3'd0:    funcOp = (opcode == opOp && instr30) ? aluSub : aluAdd;   // No SUBI
            3'd1:    funcOp = aluSll;
            3'd2:    funcOp = aluSlt;
            3'd3:    funcOp = aluSltu;
            3'd4:    funcOp = aluXor;
            3'd5:    funcOp = instr30 ? aluSra : aluSrl;   // Shifts use bit 30 in both groups
            3'd6:    funcOp = aluOr;
            default: funcOp = aluAnd;
        endcase
    end

    always_comb begin
        case (func3)
            3'd0:    taken = flags.eq;     // BEQ
            3'd1:    taken = !flags.eq;    // BNE
            3'd4:    taken = flags.lt;     // BLT
            3'd5:    taken = !flags.lt;    // BGE
            3'd6:    taken = flags.ltu;    // BLTU
            3'd7:    taken = !flags.ltu;   // BGEU
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl       = '0;
        ctrl.aSel  = aPc;
        ctrl.bSel  = bFour;
        ctrl.wbSel = wbAlu;
        ctrl.aluOp = aluAdd;
        case (state)
            stFetch: begin
                ctrl.irWrite = 1'b1;   // PC+4 from ALU
                ctrl.pcWrite = 1'b1;
            end
            stDecode: begin
                // Jump or branch target into ALU out
                ctrl.aluOutWrite = 1'b1;
                ctrl.aSel        = (opcode == opJalr) ? aRs1 : aOldPc;
                ctrl.bSel        = bImm;
            end
            stExecute: begin
                case (opcode)
                    opOp, opOpImm: begin
                        ctrl.aSel        = aRs1;
                        ctrl.bSel        = (opcode == opOp) ? bRs2 : bImm;
                        ctrl.aluOp       = funcOp;
                        ctrl.aluOutWrite = 1'b1;
                    end
                    opLoad, opStore: begin
                        ctrl.aSel        = aRs1;   // Effective address
                        ctrl.bSel        = bImm;
                        ctrl.aluOutWrite = 1'b1;
                    end
                    opLui: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.wbSel    = wbImm;
                    end
                    opAuipc: begin
                        ctrl.regWrite = 1'b1;   // oldPc+imm from decode
                        ctrl.wbSel    = wbAlu;
                    end
                    opJal, opJalr: begin
                        ctrl.regWrite = 1'b1;   // Link is PC, already +4
                        ctrl.wbSel    = wbLink;
                        ctrl.pcWrite  = 1'b1;
                    end
                    opBranch: begin
                        ctrl.aSel    = aRs1;   // Flags compare rs1 with rs2
                        ctrl.bSel    = bRs2;
                        ctrl.pcWrite = taken;
                    end
                    default: ;
                endcase
            end
            stMemory: begin
                case (opcode)
                    opStore: begin
                        ctrl.adrFromAlu = 1'b1;
                        ctrl.memWe      = 1'b1;
                    end
                    opLoad: begin
                        ctrl.adrFromAlu = 1'b1;
                        ctrl.mdrWrite   = 1'b1;
                    end
                    opOp, opOpImm: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.wbSel    = wbAlu;
                    end
                    default: ;
                endcase
            end
            default: begin
                if (opcode == opLoad) begin   // Writeback of load data
                    ctrl.regWrite = 1'b1;
                    ctrl.wbSel    = wbMdr;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/rvDatapath.sv */
// Word accesses only; addresses are used as given, with no alignment check
`default_nettype none

module rvDatapath import rvPkg::*; #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  wire           clk,
    input  wire           arstN,
    input  wire ctrlBus_t ctrl,
    input  wire [31:0]    memRdata,
    input  wire [31:0]    aluResult,
    input  wire [31:0]    rs1Data,
    input  wire [31:0]    rs2Data,
    output memReq_t       mem,
    output rvOpcode_e     opcode,
    output logic [2:0]    func3,
    output logic          instr30,
    output logic [31:0]   aluA,
    output logic [31:0]   aluB,
    output logic [4:0]    rs1Addr,
    output logic [4:0]    rs2Addr,
    output logic [4:0]    rdAddr,
    output logic [31:0]   rdData,
    output logic          rdWe
);

    logic [31:0] pc;       // Points past the current instruction after fetch
    logic [31:0] oldPc;    // PC of the current instruction
    logic [31:0] ir;
    logic [31:0] mdr;
    logic [31:0] aluOut;
    logic [31:0] imm;
    logic [31:0] pcNext;

    // Fetch takes PC+4 from the ALU; jumps and branches take the decode target
    assign pcNext = ctrl.irWrite ? aluResult : {aluOut[31:1], 1'b0};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc    <= resetPc;
            oldPc <= resetPc;
            ir    <= '0;
        end else begin
            if (ctrl.pcWrite) pc <= pcNext;
            if (ctrl.irWrite) begin
                ir    <= memRdata;
                oldPc <= pc;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mdr    <= '0;
            aluOut <= '0;
        end else begin
            if (ctrl.mdrWrite)    mdr    <= memRdata;
            if (ctrl.aluOutWrite) aluOut <= aluResult;
        end
    end

    assign opcode  = rvOpcode_e'(ir[6:0]);
    assign func3   = ir[14:12];
    assign instr30 = ir[30];
    assign rs1Addr = ir[19:15];
    assign rs2Addr = ir[24:20];
    assign rdAddr  = ir[11:7];

    always_comb begin
        case (opcode)
            opStore:        imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            opBranch:       imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            opLui, opAuipc: imm = {ir[31:12], 12'b0};
            opJal:          imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:        imm = {{20{ir[31]}}, ir[31:20]};   // I format
        endcase
    end

    always_comb begin
        case (ctrl.aSel)
            aRs1:    aluA = rs1Data;
            aOldPc:  aluA = oldPc;
            default: aluA = pc;
        endcase
        case (ctrl.bSel)
            bRs2:    aluB = rs2Data;
            bImm:    aluB = imm;
            default: aluB = 32'd4;
        endcase
        case (ctrl.wbSel)
            wbMdr:   rdData = mdr;
            wbImm:   rdData = imm;
            wbLink:  rdData = pc;
            default: rdData = aluOut;
        endcase
    end

    assign rdWe      = ctrl.regWrite && (rdAddr != 5'd0);   // x0 never written
    assign mem.addr  = ctrl.adrFromAlu ? aluOut : pc;
    assign mem.wdata = rs2Data;
    assign mem.we    = ctrl.memWe;

endmodule

`default_nettype wire

/* design/rvCore.sv */
// Single shared memory port; memRdata must answer mem.addr in the same cycle
`default_nettype none

module rvCore import rvPkg::*; #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  wire        clk,
    input  wire        arstN,
    input  wire [31:0] memRdata,
    output memReq_t    mem
);

    ctrlBus_t    ctrl;
    rvOpcode_e   opcode;
    logic [2:0]  func3;
    logic        instr30;
    cmpFlags_t   flags;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [4:0]  rs1Addr;
    logic [4:0]  rs2Addr;
    logic [4:0]  rdAddr;
    logic [31:0] rdData;
    logic        rdWe;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;

    rvControl rvControl_i (
        .clk     (clk),
        .arstN   (arstN),
        .opcode  (opcode),
        .func3   (func3),
        .instr30 (instr30),
        .flags   (flags),
        .ctrl    (ctrl)
    );

    rvDatapath #(
        .resetPc (resetPc)
    ) rvDatapath_i (
        .clk       (clk),
        .arstN     (arstN),
        .ctrl      (ctrl),
        .memRdata  (memRdata),
        .aluResult (aluResult),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .mem       (mem),
        .opcode    (opcode),
        .func3     (func3),
        .instr30   (instr30),
        .aluA      (aluA),
        .aluB      (aluB),
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .rdAddr    (rdAddr),
        .rdData    (rdData),
        .rdWe      (rdWe)
    );

    rvAlu rvAlu_i (
        .a      (aluA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .flags  (flags)
    );

    rvRegFile rvRegFile_i (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdAddr  (rdAddr),
        .rdData  (rdData),
        .rdWe    (rdWe),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

endmodule

`default_nettype wire

/* bench/tbRvCore.sv */
// Programs run from 32'h100 in a 4 KiB aliased memory and must end with a store to 32'hFFC
`default_nettype none

module tbRvCore import rvPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcAuipc  = 7'b0010111;
    localparam logic [6:0] opcJal    = 7'b1101111;
    localparam logic [6:0] opcJalr   = 7'b1100111;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcOp     = 7'b0110011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;

    logic        clk = 1'b0;
    logic        arstN = 1'b0;
    logic [31:0] memRdata = '0;
    memReq_t     mem;

    logic [31:0] memArr [0:1023];   // Byte address bits 11:2
    logic [31:0] prog [$];          // Image placed at 32'h100
    logic [31:0] logAddr [$];       // Store log
    logic [31:0] logData [$];
    logic [31:0] expAddr [$];       // Result words to compare after the run
    logic [31:0] expData [$];
    logic        markerSeen = 1'b0;
    logic        prevWe = 1'b0;
    int          slot = 0;          // Next result slot from 32'h400
    int          checks = 0;
    int          errors = 0;
    int          busErrors = 0;     // Write enable longer than one cycle
    integer      seed = 32'h760c3386;

    rvCore #(
        .resetPc (32'h100)
    ) rvCore_i (
        .clk      (clk),
        .arstN    (arstN),
        .memRdata (memRdata),
        .mem      (mem)
    );

    always #4 clk = ~clk;   // 8 ns period

    // Memory model, image installed while reset is held
    always @(negedge clk) begin
        if (!arstN) begin
            for (int i = 0; i < 1024; i++) begin
                memArr[10'(i)] = {20'hA5A5A, i[9:0], 2'b00};   // Fill tracks the address
            end
            for (int k = 0; k < prog.size(); k++) begin
                memArr[10'(64 + k)] = prog[k];
            end
            logAddr.delete();
            logData.delete();
            markerSeen = 1'b0;
            prevWe     = 1'b0;
        end else begin
            if (mem.we) begin
                memArr[mem.addr[11:2]] = mem.wdata;
                logAddr.push_back(mem.addr);
                logData.push_back(mem.wdata);
                if (mem.addr == 32'hFFC) markerSeen = 1'b1;   // End of program
                if (prevWe) begin
                    busErrors++;
                    $display("Write enable stayed high for a second cycle at %0.1f ns",
                             $realtime);
                end
            end
            prevWe = mem.we;
        end
        memRdata = memArr[mem.addr[11:2]];   // Word at the current address
    end

    task automatic compareWord(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0.1f ns: %s, got %h, expected %h", $realtime, msg, got, exp);
        end
    endtask

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opcOp};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcStore};   // SW only
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;                     // BEQ
            3'd1:    return a != b;                     // BNE
            3'd4:    return $signed(a) < $signed(b);    // BLT
            3'd5:    return $signed(a) >= $signed(b);   // BGE
            3'd6:    return a < b;                      // BLTU
            default: return a >= b;                     // BGEU
        endcase
    endfunction

    function automatic logic [31:0] nextPc();
        return 32'h100 + 32'(prog.size()) * 32'd4;
    endfunction

    task automatic emitWord(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic newProgram();
        prog.delete();
        expAddr.delete();
        expData.delete();
        slot = 0;
    endtask

    task automatic loadImm(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] upper;
        upper = (val + 32'h800) >> 12;   // Compensates the sign of the low part
        emitWord(encU(upper[19:0], rd, opcLui));
        emitWord(encI(val[11:0], rd, 3'd0, rd, opcOpImm));
    endtask

    task automatic storeForCheck(input logic [4:0] rs, input logic [31:0] value);
        logic [11:0] addr;
        addr = 12'h400 + 12'(slot * 4);
        emitWord(encS(addr, rs, 5'd0));
        expAddr.push_back({20'b0, addr});
        expData.push_back(value);
        slot++;
    endtask

    task automatic opCheck(input logic [31:0] word, input logic [31:0] value);
        emitWord(word);   // Result lands in x3
        storeForCheck(5'd3, value);
    endtask

    task automatic finishImage();
        emitWord(encU(20'd1, 5'd30, opcLui));          // x30 = 32'h1000
        emitWord(encS(12'hFFC, 5'd30, 5'd30));         // Marker at 32'hFFC
        emitWord(encJ(21'd0, 5'd0));                   // Park in a self loop
    endtask

    task automatic resetCore();
        arstN = 1'b0;
        repeat (8) @(negedge clk);
        arstN = 1'b1;
    endtask

    task automatic waitMarker(input string name);
        int cycles;
        cycles = 0;
        while (!markerSeen && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (!markerSeen) begin
            errors++;
            $display("Timeout: the %s program did not reach its end marker in 2000 cycles", name);
        end
    endtask

    task automatic checkResults(input string name);
        for (int i = 0; i < expAddr.size(); i++) begin
            compareWord(memArr[expAddr[i][11:2]], expData[i],
                        $sformatf("%s word at %h", name, expAddr[i]));
        end
    endtask

    task automatic runProgram(input string name);
        finishImage();
        resetCore();
        waitMarker(name);
        checkResults(name);
    endtask

    task automatic testResetFetch();
        logic [31:0] addrNow;
        newProgram();
        emitWord(encI(12'd5, 5'd0, 3'd0, 5'd1, opcOpImm));   // x1 = 5
        emitWord(encI(12'd7, 5'd1, 3'd0, 5'd1, opcOpImm));   // x1 = 12
        emitWord(encI(12'd3, 5'd1, 3'd0, 5'd2, opcOpImm));   // x2 = 15
        emitWord(encI(12'd1, 5'd2, 3'd0, 5'd1, opcOpImm));   // x1 = 16
        storeForCheck(5'd1, 32'd16);                         // Store to 32'h400
        finishImage();
        resetCore();
        for (int k = 0; k < 25; k++) begin
            if (k > 0) @(negedge clk);
            // Fetch bumps the PC in cycle 0 of each instruction, store is cycle 3 of the fifth
            addrNow = (k == 23) ? 32'h400 : 32'h100 + 32'd4 * 32'((k + 4) / 5);
            compareWord(mem.addr, addrNow, $sformatf("bus address in cycle %0d", k));
            compareWord({31'b0, mem.we}, {31'b0, k == 23},
                        $sformatf("write enable in cycle %0d", k));
        end
        waitMarker("reset and fetch");
        checkResults("reset and fetch");
    endtask

    task automatic testArith();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [11:0] imm;
        logic [31:0] immSx;
        logic [4:0]  sh;
        a     = $random(seed) | 32'h80000000;   // Negative so SRA fills ones
        b     = ($random(seed) & 32'h7FFFFFFF) | 32'h1;   // Positive so SLT and SLTU differ
        r     = $random(seed);
        imm   = r[11:0];
        sh    = r[16:12] | 5'd1;   // Nonzero so SRAI and SRLI differ
        immSx = {{20{imm[11]}}, imm};
        newProgram();
        loadImm(5'd1, a);
        loadImm(5'd2, b);
        opCheck(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), a + b);
        opCheck(encR(7'h20, 5'd2, 5'd1, 3'd0, 5'd3), a - b);
        opCheck(encR(7'h00, 5'd2, 5'd1, 3'd1, 5'd3), a << b[4:0]);
        opCheck(encR(7'h00, 5'd2, 5'd1, 3'd2, 5'd3), {31'b0, $signed(a) < $signed(b)});
        opCheck(encR(7'h00, 5'd2, 5'd1, 3'd3, 5'd3), {31'b0, a < b});
        opCheck(encR(7'h00, 5'd2, 5'd1, 3'd4, 5'd3), a ^ b);
        opCheck(encR(7'h00, 5'd2, 5'd1, 3'd5, 5'd3), a >> b[4:0]);
        opCheck(encR(7'h20, 5'd2, 5'd1, 3'd5, 5'd3), $signed(a) >>> b[4:0]);
        opCheck(encR(7'h00, 5'd2, 5'd1, 3'd6, 5'd3), a | b);
        opCheck(encR(7'h00, 5'd2, 5'd1, 3'd7, 5'd3), a & b);
        opCheck(encI(imm, 5'd1, 3'd0, 5'd3, opcOpImm), a + immSx);
        opCheck(encI(imm, 5'd1, 3'd2, 5'd3, opcOpImm), {31'b0, $signed(a) < $signed(immSx)});
        opCheck(encI(imm, 5'd1, 3'd3, 5'd3, opcOpImm), {31'b0, a < immSx});
        opCheck(encI(imm, 5'd1, 3'd4, 5'd3, opcOpImm), a ^ immSx);
        opCheck(encI(imm, 5'd1, 3'd6, 5'd3, opcOpImm), a | immSx);
        opCheck(encI(imm, 5'd1, 3'd7, 5'd3, opcOpImm), a & immSx);
        opCheck(encI({7'h00, sh}, 5'd1, 3'd1, 5'd3, opcOpImm), a << sh);
        opCheck(encI({7'h00, sh}, 5'd1, 3'd5, 5'd3, opcOpImm), a >> sh);
        opCheck(encI({7'h20, sh}, 5'd1, 3'd5, 5'd3, opcOpImm), $signed(a) >>> sh);
        runProgram("arithmetic");
    endtask

    task automatic testLoadStore();
        logic [31:0] base;
        logic [31:0] val;
        logic [31:0] r;
        logic [11:0] off;
        logic [31:0] offSx;
        base  = 32'h600 + ($random(seed) & 32'h1F0);   // Clear of code and result slots
        r     = $random(seed);
        off   = {6'b0, r[5:2], 2'b00} - 12'h20;        // Word offset in -32 to 28
        offSx = {{20{off[11]}}, off};
        val   = $random(seed);
        newProgram();
        loadImm(5'd5, base);
        loadImm(5'd6, val);
        emitWord(encS(off, 5'd6, 5'd5));                      // sw x6, off(x5)
        emitWord(encI(off, 5'd5, 3'd2, 5'd7, opcLoad));       // lw x7, off(x5)
        emitWord(encR(7'h00, 5'd0, 5'd7, 3'd0, 5'd8));        // x8 = x7 + x0
        storeForCheck(5'd8, val);
        emitWord(encI(12'd123, 5'd0, 3'd0, 5'd0, opcOpImm));  // Write to x0
        emitWord(encI(off, 5'd5, 3'd2, 5'd0, opcLoad));       // Load into x0
        storeForCheck(5'd0, 32'd0);
        expAddr.push_back(base + offSx);
        expData.push_back(val);
        runProgram("load and store");
        compareWord(32'(logAddr.size()), 32'd4, "number of logged stores");
        if (logAddr.size() > 0) begin
            compareWord(logAddr[0], base + offSx, "first store address");
            compareWord(logData[0], val, "first store data");
        end
    endtask

    task automatic testBranches();
        logic [2:0]  f3s [6];
        logic [31:0] a;
        logic [31:0] b;
        f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        newProgram();
        for (int p = 0; p < 3; p++) begin
            for (int n = 0; n < 6; n++) begin
                a = $random(seed);
                b = $random(seed);
                if (p == 0) begin
                    b = a;                       // Equal
                end else if (p == 1) begin
                    a = a | 32'h80000000;        // Signed less, unsigned greater
                    b = b & 32'h7FFFFFFF;
                end else begin
                    a = a & 32'h7FFFFFFF;        // Unsigned less, signed greater
                    b = b | 32'h80000000;
                end
                loadImm(5'd1, a);
                loadImm(5'd2, b);
                emitWord(encB(13'd12, 5'd2, 5'd1, f3s[n]));
                emitWord(encI(12'd1, 5'd0, 3'd0, 5'd3, opcOpImm));   // Not taken path
                emitWord(encJ(21'd8, 5'd0));
                emitWord(encI(12'd2, 5'd0, 3'd0, 5'd3, opcOpImm));   // Taken path
                storeForCheck(5'd3, branchTaken(f3s[n], a, b) ? 32'd2 : 32'd1);
            end
        end
        runProgram("branch");
    endtask

    task automatic testJumps();
        logic [31:0] p;
        logic [31:0] u;
        newProgram();
        p = nextPc();
        emitWord(encJ(21'd12, 5'd1));                         // jal x1, +12
        emitWord(encI(12'd1, 5'd0, 3'd0, 5'd4, opcOpImm));    // Skipped
        emitWord(encI(12'd1, 5'd0, 3'd0, 5'd4, opcOpImm));    // Skipped
        emitWord(encU(20'd0, 5'd5, opcAuipc));                // Landing PC into x5
        storeForCheck(5'd1, p + 32'd4);
        storeForCheck(5'd5, p + 32'd12);
        p = nextPc() + 32'd8;                                 // JALR sits after loadImm
        loadImm(5'd6, p + 32'd5);                             // Odd sum, bit 0 must clear
        emitWord(encI(12'd8, 5'd6, 3'd0, 5'd7, opcJalr));
        emitWord(encI(12'd2, 5'd0, 3'd0, 5'd4, opcOpImm));    // Skipped
        emitWord(encI(12'd3, 5'd0, 3'd0, 5'd4, opcOpImm));    // Skipped
        emitWord(encU(20'd0, 5'd8, opcAuipc));
        storeForCheck(5'd7, p + 32'd4);
        storeForCheck(5'd8, p + 32'd12);
        storeForCheck(5'd4, 32'd0);
        u = $random(seed);
        emitWord(encU(u[19:0], 5'd9, opcLui));
        storeForCheck(5'd9, {u[19:0], 12'b0});
        u = $random(seed);
        p = nextPc();
        emitWord(encU(u[19:0], 5'd10, opcAuipc));
        storeForCheck(5'd10, p + {u[19:0], 12'b0});
        runProgram("jump and upper immediate");
    endtask

    initial begin
        testResetFetch();
        testArith();
        testLoadStore();
        testBranches();
        testJumps();
        $display("Checks: %0d, errors: %0d, bus errors: %0d", checks, errors, busErrors);
        if (errors == 0 && busErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
design/rvPkg.sv
design/rvAlu.sv
design/rvRegFile.sv
design/rvControl.sv
design/rvDatapath.sv
design/rvCore.sv
bench/tbRvCore.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it; fails unless the pass message appears
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tbRvCore -o simRvCore

out=$(./obj_dir/simRvCore)
echo "$out"
echo "$out" | grep -q "All tests passed"
